// File: build.f
+incdir+hw
hw/core_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/core_control.sv
hw/core_top.sv
verification/tb_core.sv

// File: hw/core_control.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_control
    import core_pkg::*;
#(
    parameter logic [`NET_ID_W-1:0] NET_ID = `NET_ID_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 n_reset,
    input  logic [`NET_ID_W-1:0] net_id_i,
    input  net_op_e              net_op_i,
    input  logic [`PC_W-1:0]     net_addr_i,
    input  logic [`DATA_W-1:0]   net_data_i,
    input  opcode_e              opcode3_i,
    input  logic [`DATA_W-1:0]   wb_val3_i,
    output logic                 imem_we_o,
    output logic                 net_rf_we_o,
    output logic                 pc_load_o,
    output logic                 stall_o,
    output logic                 flush_o,
    output logic [`MASK_W-1:0]   barrier_o,
    output logic                 exception_o,
    output logic                 running_o
);

    logic              id_match;
    logic              cmd_reg;
    logic              cmd_pc;
    logic              cmd_bar;
    core_state_e       state_r;
    core_state_e       state_n;
    logic              exception_r;
    logic [`MASK_W-1:0] mask_r;
    logic [`MASK_W-1:0] barrier_r;

    // Packet addressed to this core
    assign id_match = (net_id_i == NET_ID) && (net_op_i != NET_NONE);

    assign imem_we_o = id_match && (net_op_i == NET_INSTR);
    assign cmd_reg   = id_match && (net_op_i == NET_REG);
    assign cmd_pc    = id_match && (net_op_i == NET_PC);
    assign cmd_bar   = id_match && (net_op_i == NET_BAR);

    // r0 is constant zero, so a network write there is ignored
    assign net_rf_we_o = cmd_reg && (net_addr_i[`RS_W-1:0] != '0);

    // Start only from IDLE
    assign pc_load_o = cmd_pc && (state_r == IDLE);
    assign flush_o   = pc_load_o;

    // Network writes own the memory and register ports for the cycle
    assign stall_o = (state_r != RUN) || imem_we_o || net_rf_we_o;

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            IDLE:
                if (cmd_pc)
                    state_n = RUN;
            RUN:
            begin
                // Restart attempt while busy is fatal
                if (cmd_pc)
                    state_n = ERR;
                else if (!stall_o && (opcode3_i == DONE))
                    state_n = IDLE;
            end
            default:
                state_n = ERR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= IDLE;
            exception_r <= 1'b0;
            mask_r      <= '0;
            barrier_r   <= '0;
        end
        else
        begin
            state_r <= state_n;
            // Sticky until reset
            if (cmd_pc && (state_r != IDLE))
                exception_r <= 1'b1;
            // Mask is frozen once in ERR
            if (cmd_bar && (state_r != ERR))
                mask_r <= net_data_i[`MASK_W-1:0];
            // BAR commits from stage 3
            if (!stall_o && (opcode3_i == BAR))
                barrier_r <= wb_val3_i[`MASK_W-1:0];
        end
    end

    assign barrier_o   = mask_r & barrier_r;
    assign exception_o = exception_r;
    assign running_o   = (state_r == RUN);

endmodule

// File: hw/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Instruction word layout, opcode on top, then rd, then rs_imm
`define INSTR_W 16
`define OPC_W 5
`define RD_W 5
// Source or immediate field, also the register file address
`define RS_W 6

// Instruction memory address
`define PC_W 10

// Register values and packet payload
`define DATA_W 32

// Barrier output and its mask
`define MASK_W 8

// Network ID width and the ID this core answers to
`define NET_ID_W 10
`define NET_ID_DEFAULT 10'd1

`endif

// File: hw/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // Instruction opcodes
    typedef enum logic [`OPC_W-1:0] {
        NOP = 0,
        ADDU,
        SUBU,
        AND,
        OR,
        SLLV,
        MOV,
        BEQZ,
        BNEQZ,
        BLTZ,
        BGTZ,
        BAR,
        DONE
    } opcode_e;

    // Network commands, NET_NONE means no packet this cycle
    typedef enum logic [2:0] {
        NET_NONE = 0,
        NET_INSTR,
        NET_REG,
        NET_PC,
        NET_BAR
    } net_op_e;

    // Run state of the core
    typedef enum logic [1:0] {
        IDLE = 0,
        RUN,
        ERR
    } core_state_e;

    // Bubble that fills a squashed or flushed stage
    localparam logic [`INSTR_W-1:0] NOP_INSTR = {NOP, {(`INSTR_W-`OPC_W){1'b0}}};

endpackage

// File: hw/core_top.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_top
    import core_pkg::*;
#(
    parameter logic [`NET_ID_W-1:0] NET_ID = `NET_ID_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 n_reset,
    input  logic [`NET_ID_W-1:0] net_id_i,
    input  net_op_e              net_op_i,
    input  logic [`PC_W-1:0]     net_addr_i,
    input  logic [`DATA_W-1:0]   net_data_i,
    output logic [`MASK_W-1:0]   barrier_o,
    output logic                 exception_o,
    output logic                 running_o
);

    // Control strobes
    logic stall;
    logic flush;
    logic pc_load;
    logic imem_we;
    logic net_rf_we;

    // Stage 1
    logic [`INSTR_W-1:0] instr1;
    logic [`PC_W-1:0]    pc1;
    logic [`RS_W-1:0]    rs_addr;
    logic [`RS_W-1:0]    rd_addr;
    logic [`DATA_W-1:0]  rs_val;
    logic [`DATA_W-1:0]  rd_val;

    // Stage 2
    logic [`INSTR_W-1:0] instr2;
    logic [`PC_W-1:0]    pc2;
    logic [`DATA_W-1:0]  rs_val2;
    logic [`DATA_W-1:0]  rd_val2;
    logic [`RS_W-1:0]    rd_addr2;
    logic                writes2;
    opcode_e             opcode2;
    logic [`DATA_W-1:0]  ex_result;
    logic                branch_taken;
    logic [`PC_W-1:0]    branch_target;

    // Stage 3 and register file write port
    logic [`RS_W-1:0]    wb_addr3;
    logic [`DATA_W-1:0]  wb_val3;
    logic                wb_en3;
    opcode_e             opcode3;
    logic                rf_we;
    logic [`RS_W-1:0]    rf_w_addr;
    logic [`DATA_W-1:0]  rf_w_data;

    assign opcode2 = opcode_e'(instr2[`INSTR_W-1 -: `OPC_W]);

    // Network write takes the port, a stalled pipeline never writes
    assign rf_we     = net_rf_we || (wb_en3 && !stall);
    assign rf_w_addr = net_rf_we ? net_addr_i[`RS_W-1:0] : wb_addr3;
    assign rf_w_data = net_rf_we ? net_data_i : wb_val3;

    core_control #(.NET_ID(NET_ID)) u_control (
        .clk(clk), .n_reset(n_reset),
        .net_id_i(net_id_i), .net_op_i(net_op_i),
        .net_addr_i(net_addr_i), .net_data_i(net_data_i),
        .opcode3_i(opcode3), .wb_val3_i(wb_val3),
        .imem_we_o(imem_we), .net_rf_we_o(net_rf_we), .pc_load_o(pc_load),
        .stall_o(stall), .flush_o(flush),
        .barrier_o(barrier_o), .exception_o(exception_o), .running_o(running_o)
    );

    fetch_unit u_fetch (
        .clk(clk), .n_reset(n_reset),
        .stall_i(stall), .flush_i(flush), .pc_load_i(pc_load),
        .imem_we_i(imem_we), .net_addr_i(net_addr_i), .net_data_i(net_data_i),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .opcode2_i(opcode2),
        .instr1_o(instr1), .pc1_o(pc1)
    );

    reg_file u_rf (
        .clk(clk),
        .rs_addr_i(rs_addr), .rd_addr_i(rd_addr),
        .we_i(rf_we), .w_addr_i(rf_w_addr), .w_data_i(rf_w_data),
        .rs_val_o(rs_val), .rd_val_o(rd_val)
    );

    operand_stage u_operand (
        .clk(clk), .n_reset(n_reset),
        .stall_i(stall), .flush_i(flush), .branch_taken_i(branch_taken),
        .instr1_i(instr1), .pc1_i(pc1),
        .rs_val_i(rs_val), .rd_val_i(rd_val), .ex_result_i(ex_result),
        .wb_addr3_i(wb_addr3), .wb_val3_i(wb_val3), .wb_en3_i(wb_en3),
        .rs_addr_o(rs_addr), .rd_addr_o(rd_addr),
        .instr2_o(instr2), .pc2_o(pc2),
        .rs_val2_o(rs_val2), .rd_val2_o(rd_val2),
        .rd_addr2_o(rd_addr2), .writes2_o(writes2)
    );

    execute_stage u_execute (
        .clk(clk), .n_reset(n_reset), .stall_i(stall),
        .instr2_i(instr2), .pc2_i(pc2),
        .rs_val2_i(rs_val2), .rd_val2_i(rd_val2),
        .rd_addr2_i(rd_addr2), .writes2_i(writes2),
        .ex_result_o(ex_result),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .wb_addr3_o(wb_addr3), .wb_val3_o(wb_val3), .wb_en3_o(wb_en3),
        .opcode3_o(opcode3)
    );

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                stall_i,
    input  logic [`INSTR_W-1:0] instr2_i,
    input  logic [`PC_W-1:0]    pc2_i,
    input  logic [`DATA_W-1:0]  rs_val2_i,
    input  logic [`DATA_W-1:0]  rd_val2_i,
    input  logic [`RS_W-1:0]    rd_addr2_i,
    input  logic                writes2_i,
    output logic [`DATA_W-1:0]  ex_result_o,
    output logic                branch_taken_o,
    output logic [`PC_W-1:0]    branch_target_o,
    output logic [`RS_W-1:0]    wb_addr3_o,
    output logic [`DATA_W-1:0]  wb_val3_o,
    output logic                wb_en3_o,
    output opcode_e             opcode3_o
);

    opcode_e          opcode2;
    logic [`RS_W-1:0] imm2;

    assign opcode2 = opcode_e'(instr2_i[`INSTR_W-1 -: `OPC_W]);
    assign imm2    = instr2_i[`RS_W-1:0];

    // Two-operand ALU, rd is both source and destination
    always_comb
    begin
        case (opcode2)
            ADDU:    ex_result_o = rd_val2_i + rs_val2_i;
            SUBU:    ex_result_o = rd_val2_i - rs_val2_i;
            AND:     ex_result_o = rd_val2_i & rs_val2_i;
            OR:      ex_result_o = rd_val2_i | rs_val2_i;
            SLLV:    ex_result_o = rd_val2_i << rs_val2_i[4:0];
            MOV:     ex_result_o = rs_val2_i;
            // BAR carries rd through to stage 3 for the barrier
            BAR:     ex_result_o = rd_val2_i;
            default: ex_result_o = '0;
        endcase
    end

    // Zero tests on rd
    always_comb
    begin
        case (opcode2)
            BEQZ:    branch_taken_o = (rd_val2_i == '0);
            BNEQZ:   branch_taken_o = (rd_val2_i != '0);
            BLTZ:    branch_taken_o = $signed(rd_val2_i) < 0;
            BGTZ:    branch_taken_o = $signed(rd_val2_i) > 0;
            default: branch_taken_o = 1'b0;
        endcase
    end

    // Offset is relative to the branch itself
    assign branch_target_o = pc2_i + {{(`PC_W-`RS_W){imm2[`RS_W-1]}}, imm2};

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            wb_en3_o  <= 1'b0;
            opcode3_o <= NOP;
        end
        else if (!stall_i)
        begin
            wb_en3_o  <= writes2_i;
            opcode3_o <= opcode2;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            wb_addr3_o <= rd_addr2_i;
            wb_val3_o  <= ex_result_o;
        end
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_unit
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                stall_i,
    input  logic                flush_i,
    input  logic                pc_load_i,
    input  logic                imem_we_i,
    input  logic [`PC_W-1:0]    net_addr_i,
    input  logic [`DATA_W-1:0]  net_data_i,
    input  logic                branch_taken_i,
    input  logic [`PC_W-1:0]    branch_target_i,
    input  opcode_e             opcode2_i,
    output logic [`INSTR_W-1:0] instr1_o,
    output logic [`PC_W-1:0]    pc1_o
);

    // Program storage, written only by the network
    logic [`INSTR_W-1:0] imem [0:(1<<`PC_W)-1];

    // Address of the next instruction to read
    logic [`PC_W-1:0] pc_r;
    logic [`PC_W-1:0] pc_next;
    opcode_e          opcode1;
    logic             done_ahead;

    assign opcode1 = opcode_e'(instr1_o[`INSTR_W-1 -: `OPC_W]);
    // No new fetch while the program is ending
    assign done_ahead = (opcode1 == DONE) || (opcode2_i == DONE);

    // Network load wins, stall holds, then branch, else sequential
    always_comb
    begin
        if (pc_load_i)
            pc_next = net_addr_i;
        else if (stall_i)
            pc_next = pc_r;
        else if (branch_taken_i)
            pc_next = branch_target_i;
        else
            pc_next = pc_r + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_next;
    end

    always_ff @(posedge clk)
    begin
        if (imem_we_i)
            imem[net_addr_i] <= net_data_i[`INSTR_W-1:0];
    end

    // Synchronous read straight into the stage-1 register
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            instr1_o <= NOP_INSTR;
        else if (flush_i)
            instr1_o <= NOP_INSTR;
        else if (!stall_i)
        begin
            // Wrong-path fetch after a taken branch becomes a bubble
            if (branch_taken_i || done_ahead)
                instr1_o <= NOP_INSTR;
            else
                instr1_o <= imem[pc_r];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
            pc1_o <= pc_r;
    end

endmodule

// File: hw/operand_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module operand_stage
    import core_pkg::*;
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                stall_i,
    input  logic                flush_i,
    input  logic                branch_taken_i,
    input  logic [`INSTR_W-1:0] instr1_i,
    input  logic [`PC_W-1:0]    pc1_i,
    input  logic [`DATA_W-1:0]  rs_val_i,
    input  logic [`DATA_W-1:0]  rd_val_i,
    input  logic [`DATA_W-1:0]  ex_result_i,
    input  logic [`RS_W-1:0]    wb_addr3_i,
    input  logic [`DATA_W-1:0]  wb_val3_i,
    input  logic                wb_en3_i,
    output logic [`RS_W-1:0]    rs_addr_o,
    output logic [`RS_W-1:0]    rd_addr_o,
    output logic [`INSTR_W-1:0] instr2_o,
    output logic [`PC_W-1:0]    pc2_o,
    output logic [`DATA_W-1:0]  rs_val2_o,
    output logic [`DATA_W-1:0]  rd_val2_o,
    output logic [`RS_W-1:0]    rd_addr2_o,
    output logic                writes2_o
);

    opcode_e            opcode1;
    logic               writes1;
    logic [`DATA_W-1:0] rs_fwd;
    logic [`DATA_W-1:0] rd_fwd;

    // Youngest producer first, the register file last
    function automatic logic [`DATA_W-1:0] forward(input logic [`RS_W-1:0] addr,
                                                   input logic [`DATA_W-1:0] rf_val);
        if (writes2_o && (rd_addr2_o == addr))
            return ex_result_i;
        else if (wb_en3_i && (wb_addr3_i == addr))
            return wb_val3_i;
        else
            return rf_val;
    endfunction

    assign opcode1   = opcode_e'(instr1_i[`INSTR_W-1 -: `OPC_W]);
    assign rs_addr_o = instr1_i[`RS_W-1:0];
    // rd field is narrower, so only the low registers can be a destination
    assign rd_addr_o = {{(`RS_W-`RD_W){1'b0}}, instr1_i[`RS_W +: `RD_W]};

    // ALU ops write rd, except that writes to r0 are dropped
    always_comb
    begin
        case (opcode1)
            ADDU, SUBU, AND, OR, SLLV, MOV: writes1 = (rd_addr_o != '0);
            default:                        writes1 = 1'b0;
        endcase
    end

    always_comb
    begin
        rs_fwd = forward(rs_addr_o, rs_val_i);
        rd_fwd = forward(rd_addr_o, rd_val_i);
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            instr2_o  <= NOP_INSTR;
            writes2_o <= 1'b0;
        end
        else if (flush_i || (!stall_i && branch_taken_i))
        begin
            // Squash the instruction behind a taken branch
            instr2_o  <= NOP_INSTR;
            writes2_o <= 1'b0;
        end
        else if (!stall_i)
        begin
            instr2_o  <= instr1_i;
            writes2_o <= writes1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            pc2_o      <= pc1_i;
            rs_val2_o  <= rs_fwd;
            rd_val2_o  <= rd_fwd;
            rd_addr2_o <= rd_addr_o;
        end
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file
(
    input  logic               clk,
    input  logic [`RS_W-1:0]   rs_addr_i,
    input  logic [`RS_W-1:0]   rd_addr_i,
    input  logic               we_i,
    input  logic [`RS_W-1:0]   w_addr_i,
    input  logic [`DATA_W-1:0] w_data_i,
    output logic [`DATA_W-1:0] rs_val_o,
    output logic [`DATA_W-1:0] rd_val_o
);

    // Upper half only reachable from the network, used as constants
    logic [`DATA_W-1:0] regs [0:(1<<`RS_W)-1];

    always_ff @(posedge clk)
    begin
        if (we_i)
            regs[w_addr_i] <= w_data_i;
    end

    // Entry 0 is hardwired to zero
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: verification/core_trace.txt
# P id op addr data, op 1 instr 2 reg 3 pc 4 mask, all hex
# W waits for a program to end, C name barrier exception running
C after_reset 00 0 0
# Program 1 at 0x000, dependent ALU chain, result 0x6c
P 001 2 020 00000005
P 001 2 021 00000003
P 001 2 022 00000037
P 001 1 000 00003060
P 001 1 001 00000861
P 001 1 002 000030a1
P 001 1 003 00002842
P 001 1 004 00001061
P 001 1 005 00001862
P 001 1 006 00002081
P 001 1 007 00000881
P 001 1 008 00005880
P 001 1 009 00006000
P 001 4 000 000000ff
P 001 3 000 00000000
W
C prog1_alu 6c 0 0
# Program 2 at 0x020, countdown loop from 4, sum 0x0a
P 001 2 024 00000004
P 001 2 025 00000001
P 001 1 020 000030e4
P 001 1 021 00003100
P 001 1 022 000038d1
P 001 1 023 00004910
P 001 1 024 00000903
P 001 1 025 000010e5
P 001 1 026 000040fe
P 001 1 027 00005103
P 001 1 028 00000924
P 001 1 029 00000924
P 001 1 02a 00005900
P 001 1 02b 00006000
P 001 1 033 00000924
P 001 1 034 00005900
P 001 1 035 00006000
P 001 3 020 00000000
W
C prog2_branch 0a 0 0
# Partial mask over the last published value
P 001 4 000 00000006
C mask_partial 02 0 0
# Other IDs, every op, no effect
P 002 1 000 00006000
P 201 2 020 00000099
P 3fe 4 000 00000000
P 201 3 020 00000000
P 000 4 000 000000ff
C foreign_id 02 0 0
P 001 4 000 000000ff
C mask_restore 0a 0 0
P 001 3 000 00000000
W
C prog1_rerun 6c 0 0
# Long loop at 0x040, restarted while busy
P 001 2 026 000000c8
P 001 1 040 000031a6
P 001 1 041 000011a5
P 001 1 042 000041bf
P 001 1 043 00005980
P 001 1 044 00006000
P 001 3 040 00000000
P 001 3 000 00000000
C pc_while_busy 6c 1 0
P 001 4 000 00000000
P 001 3 000 00000000
C err_sticky 6c 1 0

// File: verification/tb_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_core
    import core_pkg::*;
();

    localparam string TRACE_FILE = "verification/core_trace.txt";

    logic                 clk;
    logic                 n_reset;
    logic [`NET_ID_W-1:0] net_id;
    net_op_e              net_op;
    logic [`PC_W-1:0]     net_addr;
    logic [`DATA_W-1:0]   net_data;
    logic [`MASK_W-1:0]   barrier;
    logic                 exception;
    logic                 running;

    // One entry per trace line with fields that depend on the kind
    string       kind_q[$];
    string       name_q[$];
    logic [31:0] f1_q[$];
    logic [31:0] f2_q[$];
    logic [31:0] f3_q[$];
    logic [31:0] f4_q[$];

    int errors;
    int checks;
    int cycle_count;
    int cycle_limit;
    bit limit_ready;

    core_top #(.NET_ID(`NET_ID_DEFAULT)) dut (
        .clk(clk), .n_reset(n_reset),
        .net_id_i(net_id), .net_op_i(net_op),
        .net_addr_i(net_addr), .net_data_i(net_data),
        .barrier_o(barrier), .exception_o(exception), .running_o(running)
    );

    always #10 clk = ~clk;

    // Cycle budget for the whole run
    always @(posedge clk)
    begin
        if (limit_ready)
        begin
            cycle_count++;
            if (cycle_count > cycle_limit)
            begin
                $display("Run did not finish within %0d cycles", cycle_limit);
                errors++;
                $display("Checks: %0d, errors: %0d", checks, errors);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    task automatic load_trace();
        int          fd;
        int          code;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file %s", TRACE_FILE);
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            // Blank lines and comments
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            code = $sscanf(line, "%s", kind);
            name = "";
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            if (kind == "P")
                code = $sscanf(line, "%s %h %h %h %h", kind, a, b, c, d);
            else if (kind == "C")
                code = $sscanf(line, "%s %s %h %h %h", kind, name, a, b, c);
            else if (kind != "W")
            begin
                $display("Unknown trace line: %s", line);
                errors++;
                continue;
            end
            kind_q.push_back(kind);
            name_q.push_back(name);
            f1_q.push_back(a);
            f2_q.push_back(b);
            f3_q.push_back(c);
            f4_q.push_back(d);
        end
        $fclose(fd);
    endtask

    task automatic send_packet(input logic [31:0] id, input logic [31:0] op,
                               input logic [31:0] addr, input logic [31:0] data);
        int gap;
        // Random idle time on the network before each packet
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #2;
        net_id   = id[`NET_ID_W-1:0];
        net_op   = net_op_e'(op[2:0]);
        net_addr = addr[`PC_W-1:0];
        net_data = data;
        @(posedge clk);
        #2;
        net_id   = '0;
        net_op   = NET_NONE;
        net_addr = '0;
        net_data = '0;
    endtask

    // Program has ended once running_o has risen and fallen again
    task automatic wait_program_end();
        bit seen_run;
        seen_run = 1'b0;
        while (!(seen_run && !running))
        begin
            @(negedge clk);
            if (running)
                seen_run = 1'b1;
        end
    endtask

    task automatic check_outputs(input string name, input logic [31:0] exp_bar,
                                 input logic [31:0] exp_exc, input logic [31:0] exp_run);
        @(negedge clk);
        checks++;
        if (barrier !== exp_bar[`MASK_W-1:0])
        begin
            $display("[ERROR] %s: barrier_o expected %h, actual %h",
                     name, exp_bar[`MASK_W-1:0], barrier);
            errors++;
        end
        if (exception !== exp_exc[0])
        begin
            $display("[ERROR] %s: exception_o expected %b, actual %b",
                     name, exp_exc[0], exception);
            errors++;
        end
        if (running !== exp_run[0])
        begin
            $display("[ERROR] %s: running_o expected %b, actual %b",
                     name, exp_run[0], running);
            errors++;
        end
    endtask

    initial
    begin
        int waits;
        clk         = 1'b0;
        n_reset     = 1'b0;
        net_id      = '0;
        net_op      = NET_NONE;
        net_addr    = '0;
        net_data    = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        limit_ready = 1'b0;
        void'($urandom(47));
        waits       = 0;

        load_trace();
        foreach (kind_q[i])
        begin
            if (kind_q[i] == "W")
                waits++;
        end
        cycle_limit = 300 * waits + 10 * (kind_q.size() - waits) + 10;
        limit_ready = 1'b1;

        repeat (2) @(posedge clk);
        #2;
        n_reset = 1'b1;

        foreach (kind_q[i])
        begin
            if (kind_q[i] == "P")
                send_packet(f1_q[i], f2_q[i], f3_q[i], f4_q[i]);
            else if (kind_q[i] == "W")
                wait_program_end();
            else
                check_outputs(name_q[i], f1_q[i], f2_q[i], f3_q[i]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
